//--- build.f
fetch_pkg.sv
imem_if.sv
fetch_if.sv
inst_mem.sv
fetch_unit.sv
fetch_skid.sv
fetch_top.sv
tb_fetch_chk.sv
tb_fetch.sv

//--- tb_fetch.sv
// testbench for the instruction-fetch subsystem
// loads random code, then streams, stalls, busies and branches against a pc model
`timescale 1ns/100ps
`default_nettype none

module tb_fetch;
    import fetch_pkg::*;

    localparam int n_seq    = 512;
    localparam int n_bp     = 300;
    localparam int n_busy   = 150;
    localparam int n_branch = 400;
    localparam int n_total  = n_seq + n_bp + 2 * n_busy + n_branch;
    // ten cycles per requested transfer, covers load and reset as well
    localparam int timeout_cycles = 10 * n_total;

    logic               clk;
    logic               rst;
    logic               load_en;
    logic [imem_aw-1:0] load_addr;
    logic [xlen-1:0]    load_data;
    logic               mem_busy;
    logic               branch;
    logic [xlen-1:0]    branch_target;
    fetch_t             fetch;
    logic               pipe_out_vld;
    logic               pipe_out_rdy;

    integer          seed;
    int              errors;
    int              cycles = 0;
    int              checked;
    int              branches;
    logic [xlen-1:0] exp_pc;
    logic [xlen-1:0] model_mem [imem_depth];

    fetch_top u_fetch_top (
        .clk          (clk),
        .rst          (rst),
        .load_en      (load_en),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .mem_busy     (mem_busy),
        .branch       (branch),
        .branch_target(branch_target),
        .fetch        (fetch),
        .pipe_out_vld (pipe_out_vld),
        .pipe_out_rdy (pipe_out_rdy)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= timeout_cycles) begin
            $display("timeout: only %0d of %0d transfers arrived within %0d cycles",
                     checked, n_total, cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_fetch(input fetch_t got, input fetch_t exp_item);
        if (got !== exp_item) begin
            errors++;
            $display("mismatch fetch: got %h expected %h", got, exp_item);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp_bit);
        if (got !== exp_bit) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp_bit);
        end
    endtask

    // fill every word with random code and keep a copy
    task automatic load_memory();
        int              i;
        logic [xlen-1:0] word;
        for (i = 0; i < imem_depth; i++) begin
            @(negedge clk);
            word         = $random(seed);
            load_en      = 1'b1;
            load_addr    = i[imem_aw-1:0];
            load_data    = word;
            model_mem[i] = word;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_flag("pipe_out_vld", pipe_out_vld, 1'b0);
        end
        rst = 1'b0;
        // idle while the first request is issued and answered
        repeat (2) begin
            @(negedge clk);
            check_flag("pipe_out_vld", pipe_out_vld, 1'b0);
        end
    endtask

    // runs until n transfers were checked, with optional stalls, busy and branches
    task automatic run_phase(input int n, input bit bp_en, input bit busy_en, input bit br_en);
        int              done;
        int              rdy_stall;
        int              busy_stall;
        logic [xlen-1:0] tgt;
        fetch_t          exp_item;
        done       = 0;
        rdy_stall  = 0;
        busy_stall = 0;
        while (done < n) begin
            @(negedge clk);
            if (bp_en && rdy_stall == 0 && ($random(seed) & 3) == 0) begin
                rdy_stall = 1 + ($random(seed) & 3);
            end
            if (busy_en && busy_stall == 0 && ($random(seed) & 3) == 0) begin
                busy_stall = 1 + ($random(seed) & 3);
            end
            pipe_out_rdy = (rdy_stall == 0);
            mem_busy     = (busy_stall != 0);
            if (rdy_stall > 0) begin
                rdy_stall--;
            end
            if (busy_stall > 0) begin
                busy_stall--;
            end
            branch = br_en && (($random(seed) & 15) == 0);
            if (branch) begin
                // redirect, a transfer in this cycle does not count
                tgt           = $random(seed);
                tgt[1:0]      = 2'b00;
                branch_target = tgt;
                exp_pc        = tgt;
                branches++;
            end else if (pipe_out_vld && pipe_out_rdy) begin
                exp_item.pc = exp_pc;
                exp_item.ir = model_mem[exp_pc[imem_aw+1:2]];
                check_fetch(fetch, exp_item);
                exp_pc = exp_pc + 32'd4;
                checked++;
                done++;
            end
        end
    endtask

    initial begin
        seed          = 32'h3d13a201;
        clk           = 1'b0;
        rst           = 1'b0;
        load_en       = 1'b0;
        load_addr     = '0;
        load_data     = '0;
        mem_busy      = 1'b0;
        branch        = 1'b0;
        branch_target = '0;
        pipe_out_rdy  = 1'b1;
        errors        = 0;
        checked       = 0;
        branches      = 0;
        exp_pc        = reset_pc;

        load_memory();
        apply_reset();
        run_phase(n_seq, 1'b0, 1'b0, 1'b0);
        run_phase(n_bp, 1'b1, 1'b0, 1'b0);
        run_phase(n_busy, 1'b0, 1'b1, 1'b0);
        run_phase(n_busy, 1'b1, 1'b1, 1'b0);
        run_phase(n_branch, 1'b1, 1'b1, 1'b1);

        @(negedge clk);
        branch       = 1'b0;
        mem_busy     = 1'b0;
        pipe_out_rdy = 1'b1;
        errors = errors + u_fetch_top.u_fetch_chk.assert_fails;
        $display("errors: %0d (assertions %0d), transfers checked: %0d, branches: %0d",
                 errors, u_fetch_top.u_fetch_chk.assert_fails, checked, branches);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_fetch_chk.sv
// concurrent checks on the decode handshake and the memory grant
// bound into fetch_top, watches its pins and the memory port
`timescale 1ns/100ps
`default_nettype none

module fetch_chk (
    input logic              clk,
    input logic              rst,
    input logic              vld,
    input logic              rdy,
    input fetch_pkg::fetch_t fetch,
    input logic              branch,
    input logic              mem_busy,
    input logic              gnt
);

    int assert_fails = 0;

    // a stalled payload stays put until it is taken or flushed
    hold_while_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (vld && !rdy && !branch) |=> (vld && $stable(fetch))
    ) else begin
        assert_fails++;
        $error("stalled decode payload was dropped or changed");
    end

    // busy models lost arbitration, no grant may slip through
    no_grant_when_busy: assert property (
        @(posedge clk) mem_busy |-> !gnt
    ) else begin
        assert_fails++;
        $error("memory granted a request while busy");
    end

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> !vld
    ) else begin
        assert_fails++;
        $error("decode valid raised right after reset");
    end

endmodule

bind fetch_top fetch_chk u_fetch_chk (
    .clk     (clk),
    .rst     (rst),
    .vld     (pipe_out_vld),
    .rdy     (pipe_out_rdy),
    .fetch   (fetch),
    .branch  (branch),
    .mem_busy(mem_busy),
    .gnt     (imem_bus.gnt)
);

`default_nettype wire

//--- fetch_top.sv
// instruction-fetch subsystem top: memory, fetch unit and skid buffer
// decode side leaves as plain fetch/pipe_out_vld/pipe_out_rdy ports
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_en,
    input  logic [fetch_pkg::imem_aw-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]    load_data,
    input  logic                          mem_busy,
    input  logic                          branch,
    input  logic [fetch_pkg::xlen-1:0]    branch_target,
    output fetch_pkg::fetch_t             fetch,
    output logic                          pipe_out_vld,
    input  logic                          pipe_out_rdy
);
    import fetch_pkg::*;

    imem_if  imem_bus ();
    fetch_if dec_bus ();

    logic   wr_en;
    fetch_t wr_data;
    logic   room_freed;
    logic   flush;

    inst_mem u_inst_mem (
        .clk      (clk),
        .rst      (rst),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .busy     (mem_busy),
        .port     (imem_bus.mem)
    );

    fetch_unit u_fetch_unit (
        .clk          (clk),
        .rst          (rst),
        .branch       (branch),
        .branch_target(branch_target),
        .mem          (imem_bus.fetch),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .room_freed   (room_freed),
        .flush        (flush)
    );

    fetch_skid #(
        .payload_t(fetch_t)
    ) u_fetch_skid (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .flush     (flush),
        .room_freed(room_freed),
        .out       (dec_bus.src)
    );

    // decode channel out to the pins
    assign fetch        = dec_bus.payload;
    assign pipe_out_vld = dec_bus.vld;
    assign dec_bus.rdy  = pipe_out_rdy;

endmodule

`default_nettype wire

//--- fetch_skid.sv
// two-entry skid buffer toward decode, payload type is a parameter
// written by a strobe, drained by vld/rdy, emptied at once by flush
`timescale 1ns/100ps
`default_nettype none

module fetch_skid #(
    parameter type payload_t = fetch_pkg::fetch_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_en,
    input  payload_t wr_data,
    input  logic     flush,
    output logic     room_freed,
    fetch_if.src     out
);

    payload_t   buf_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    // head entry straight from the storage registers
    assign out.vld     = (count_q != 2'd0);
    assign out.payload = buf_q[rd_ptr_q];

    // a transfer in a flush cycle is not delivered
    assign pop        = out.vld & out.rdy & ~flush;
    assign push       = wr_en & ~flush;
    assign room_freed = pop;

    always_ff @(posedge clk) begin
        if (push) begin
            buf_q[wr_ptr_q] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else if (flush) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- fetch_unit.sv
// program counter and request issue toward instruction memory
// at most two credits cover requests in flight and buffered entries
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       branch,
    input  logic [fetch_pkg::xlen-1:0] branch_target,
    imem_if.fetch                      mem,
    output logic                       wr_en,
    output fetch_pkg::fetch_t          wr_data,
    input  logic                       room_freed,
    output logic                       flush
);
    import fetch_pkg::*;

    logic            run_q;
    logic [xlen-1:0] pc_q;
    logic [1:0]      credit_q;
    logic [1:0]      credit_d;
    logic            accept;
    logic            drop;

    // pcs of outstanding requests in issue order
    logic [xlen-1:0] pend_pc_q    [2];
    logic            pend_stale_q [2];
    logic            pend_wr_q;
    logic            pend_rd_q;
    logic [1:0]      pend_cnt_q;

    // a credit freed this cycle may be reused at once to keep one fetch per cycle
    assign mem.req  = run_q & ((credit_q < 2'd2) | room_freed);
    assign mem.addr = pc_q;
    assign accept   = mem.req & mem.gnt;

    assign flush = branch;

    // a response arriving in the branch cycle is stale as well
    assign drop    = mem.rvalid & (pend_stale_q[pend_rd_q] | branch);
    assign wr_en   = mem.rvalid & ~drop;
    assign wr_data = '{pc: pend_pc_q[pend_rd_q], ir: mem.rdata};

    always_comb begin
        if (branch) begin
            // the buffer is flushed so only requests still to respond hold credit
            credit_d = pend_cnt_q + {1'b0, accept} - {1'b0, mem.rvalid};
        end else begin
            credit_d = credit_q + {1'b0, accept} - {1'b0, room_freed} - {1'b0, drop};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            run_q      <= 1'b0;
            pc_q       <= reset_pc;
            credit_q   <= 2'd0;
            pend_wr_q  <= 1'b0;
            pend_rd_q  <= 1'b0;
            pend_cnt_q <= 2'd0;
        end else begin
            // first request goes out once reset is gone
            run_q      <= 1'b1;
            credit_q   <= credit_d;
            pend_cnt_q <= pend_cnt_q + {1'b0, accept} - {1'b0, mem.rvalid};

            if (branch) begin
                // low target bits are ignored
                pc_q <= {branch_target[xlen-1:2], 2'b00};
            end else if (accept) begin
                pc_q <= pc_q + xlen'(4);
            end

            if (accept) begin
                pend_wr_q <= ~pend_wr_q;
            end
            if (mem.rvalid) begin
                pend_rd_q <= ~pend_rd_q;
            end
        end
    end

    // each accepted request keeps its pc and whether a redirect made it stale
    always_ff @(posedge clk) begin
        if (accept) begin
            pend_pc_q[pend_wr_q]    <= pc_q;
            pend_stale_q[pend_wr_q] <= branch;
        end
    end

endmodule

`default_nettype wire

//--- inst_mem.sv
// word-addressed instruction memory, loaded by a write strobe before the run
// grants requests while not busy and returns the word one cycle after the grant
`timescale 1ns/100ps
`default_nettype none

module inst_mem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load_en,
    input  logic [fetch_pkg::imem_aw-1:0] load_addr,
    input  logic [fetch_pkg::xlen-1:0]    load_data,
    input  logic                          busy,
    imem_if.mem                           port
);
    import fetch_pkg::*;

    logic [xlen-1:0]    mem_q [imem_depth];
    logic [imem_aw-1:0] word_idx;
    logic [xlen-1:0]    rdata_q;
    logic               rvalid_q;

    // byte address to word index, upper bits wrap
    assign word_idx = port.addr[imem_aw+1:2];

    // busy models a lost arbitration or a miss
    assign port.gnt = port.req & ~busy;

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem_q[load_addr] <= load_data;
        end
    end

    // read data only moves on a grant
    always_ff @(posedge clk) begin
        if (port.gnt) begin
            rdata_q <= mem_q[word_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= port.gnt;
        end
    end

    assign port.rvalid = rvalid_q;
    assign port.rdata  = rdata_q;

endmodule

`default_nettype wire

//--- fetch_if.sv
// valid/ready channel carrying one fetched pc/instruction pair
`timescale 1ns/100ps
`default_nettype none

interface fetch_if;
    import fetch_pkg::*;

    fetch_t payload;
    logic   vld;
    logic   rdy;

    modport src (
        output payload,
        output vld,
        input  rdy
    );

    modport dst (
        input  payload,
        input  vld,
        output rdy
    );

endinterface

`default_nettype wire

//--- imem_if.sv
// request/grant port between the fetch unit and the instruction memory
// fetch issues req/addr, memory answers with gnt and a one-cycle rvalid/rdata
`timescale 1ns/100ps
`default_nettype none

interface imem_if;
    import fetch_pkg::*;

    logic            req;
    logic            gnt;
    logic [xlen-1:0] addr;
    logic            rvalid;
    logic [xlen-1:0] rdata;

    // requester side
    modport fetch (
        output req,
        output addr,
        input  gnt,
        input  rvalid,
        input  rdata
    );

    // responder side
    modport mem (
        input  req,
        input  addr,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

`default_nettype wire

//--- fetch_pkg.sv
// shared widths, reset address and the fetch-to-decode payload type
// imported by every RTL block of the instruction-fetch subsystem
`default_nettype none

package fetch_pkg;

    // data and address width
    localparam int xlen = 32;

    // first address fetched after reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // instruction memory size in 32-bit words
    localparam int imem_depth = 256;

    // word address width, byte address bits 9..2 select the word
    localparam int imem_aw = 8;

    // payload handed from fetch to decode
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic [xlen-1:0] ir;
    } fetch_t;

endpackage

`default_nettype wire
